// ==== include/mul_unit_cfg.svh ====
`ifndef MUL_UNIT_CFG_SVH
`define MUL_UNIT_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Multiply unit configuration
////////////////////////////////////////////////////////////////////////////

// Hardware threads, at least two
`define MUL_THREADS 4

// Operand width, the product is twice this
`define MUL_DATA_WIDTH 32

// Reorder buffer tag width
`define MUL_ROB_ID_WIDTH 6

// Program counter width
`define MUL_PC_WIDTH 32

// Destination register address width
`define MUL_REG_ADDR_WIDTH 5

// Pipeline depth
// Must divide MUL_DATA_WIDTH, one operand slice per stage
`define MUL_STAGES 4

`endif

// ==== hdl/mul_data_pkg.sv ====
`include "mul_unit_cfg.svh"

package mul_data_pkg;

    // Operand or low result word
    typedef logic [`MUL_DATA_WIDTH-1:0] word_t;

    // Full product, upper half feeds overflow
    typedef logic [2*`MUL_DATA_WIDTH-1:0] product_t;

    // Instruction tag from the reorder buffer
    typedef logic [`MUL_ROB_ID_WIDTH-1:0] rob_id_t;

    // Destination register
    typedef logic [`MUL_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Program counter
    typedef logic [`MUL_PC_WIDTH-1:0] pc_t;

    // Thread number
    typedef logic [$clog2(`MUL_THREADS)-1:0] thread_id_t;

endpackage

// ==== hdl/mul_ctrl_pkg.sv ====
`include "mul_unit_cfg.svh"

package mul_ctrl_pkg;

    // One bit per hardware thread
    typedef logic [`MUL_THREADS-1:0] thread_mask_t;

    // Request slot life cycle
    typedef enum logic [1:0] {
        SLOT_EMPTY   = 2'd0,
        SLOT_WAITING = 2'd1,
        SLOT_READY   = 2'd2
    } slot_state_e;

endpackage

// ==== hdl/operand_collector.sv ====
`timescale 1ns/1ps
`include "mul_unit_cfg.svh"

module operand_collector
(
    input  logic                       clock,
    input  logic                       rst_n,

    input  logic                       req_valid,
    input  mul_data_pkg::thread_id_t   req_thread,
    input  mul_data_pkg::rob_id_t      req_rob_id,
    input  mul_data_pkg::pc_t          req_pc,
    input  mul_data_pkg::reg_addr_t    req_rd,
    input  mul_data_pkg::word_t        req_src1_data,
    input  logic                       req_src1_pending,
    input  mul_data_pkg::rob_id_t      req_src1_rob_id,
    input  mul_data_pkg::word_t        req_src2_data,
    input  logic                       req_src2_pending,
    input  mul_data_pkg::rob_id_t      req_src2_rob_id,

    input  logic                       wr_valid,
    input  mul_data_pkg::thread_id_t   wr_thread,
    input  mul_data_pkg::rob_id_t      wr_rob_id,
    input  mul_data_pkg::word_t        wr_data,

    input  mul_ctrl_pkg::thread_mask_t flush,
    input  mul_ctrl_pkg::thread_mask_t grant,

    output mul_ctrl_pkg::thread_mask_t stall_decode,
    output mul_ctrl_pkg::thread_mask_t slot_ready,
    output mul_data_pkg::thread_id_t   iss_thread,
    output mul_data_pkg::rob_id_t      iss_rob_id,
    output mul_data_pkg::pc_t          iss_pc,
    output mul_data_pkg::reg_addr_t    iss_rd,
    output mul_data_pkg::word_t        iss_src1,
    output mul_data_pkg::word_t        iss_src2
);

////////////////////////////////////////////////////////////////////////////
// Slot storage
////////////////////////////////////////////////////////////////////////////

mul_ctrl_pkg::slot_state_e  state_q [`MUL_THREADS];
mul_ctrl_pkg::thread_mask_t pend1_q;
mul_ctrl_pkg::thread_mask_t pend2_q;
mul_data_pkg::rob_id_t      dep1_q  [`MUL_THREADS];
mul_data_pkg::rob_id_t      dep2_q  [`MUL_THREADS];
mul_data_pkg::word_t        src1_q  [`MUL_THREADS];
mul_data_pkg::word_t        src2_q  [`MUL_THREADS];
mul_data_pkg::rob_id_t      rob_id_q[`MUL_THREADS];
mul_data_pkg::pc_t          pc_q    [`MUL_THREADS];
mul_data_pkg::reg_addr_t    rd_q    [`MUL_THREADS];

mul_ctrl_pkg::thread_mask_t accept;
mul_ctrl_pkg::thread_mask_t cap1;
mul_ctrl_pkg::thread_mask_t cap2;
mul_ctrl_pkg::thread_mask_t p1_next;
mul_ctrl_pkg::thread_mask_t p2_next;

logic req_hit1;
logic req_hit2;

// Broadcast landing in the same cycle as the request
assign req_hit1 = wr_valid && (wr_thread == req_thread) && req_src1_pending
                  && (wr_rob_id == req_src1_rob_id);
assign req_hit2 = wr_valid && (wr_thread == req_thread) && req_src2_pending
                  && (wr_rob_id == req_src2_rob_id);

always_comb
begin
    for (int t = 0; t < `MUL_THREADS; t++)
    begin
        accept[t] = req_valid && (req_thread == mul_data_pkg::thread_id_t'(t));
        // Parked sources snoop the register file write
        cap1[t] = wr_valid && (wr_thread == mul_data_pkg::thread_id_t'(t))
                  && pend1_q[t] && (wr_rob_id == dep1_q[t]);
        cap2[t] = wr_valid && (wr_thread == mul_data_pkg::thread_id_t'(t))
                  && pend2_q[t] && (wr_rob_id == dep2_q[t]);
        p1_next[t] = accept[t] ? (req_src1_pending && !req_hit1) : (pend1_q[t] && !cap1[t]);
        p2_next[t] = accept[t] ? (req_src2_pending && !req_hit2) : (pend2_q[t] && !cap2[t]);

        stall_decode[t] = (state_q[t] != mul_ctrl_pkg::SLOT_EMPTY);
        slot_ready[t]   = (state_q[t] == mul_ctrl_pkg::SLOT_READY);
    end
end

always_ff @(posedge clock)
begin
    for (int t = 0; t < `MUL_THREADS; t++)
    begin
        if (!rst_n || flush[t])
        begin
            state_q[t] <= mul_ctrl_pkg::SLOT_EMPTY;
            pend1_q[t] <= 1'b0;
            pend2_q[t] <= 1'b0;
        end
        else if (grant[t])
        begin
            state_q[t] <= mul_ctrl_pkg::SLOT_EMPTY;
        end
        else if (accept[t] || state_q[t] == mul_ctrl_pkg::SLOT_WAITING)
        begin
            pend1_q[t] <= p1_next[t];
            pend2_q[t] <= p2_next[t];
            state_q[t] <= (p1_next[t] || p2_next[t]) ? mul_ctrl_pkg::SLOT_WAITING
                                                     : mul_ctrl_pkg::SLOT_READY;
        end
    end
end

always_ff @(posedge clock)
begin
    for (int t = 0; t < `MUL_THREADS; t++)
    begin
        if (accept[t])
        begin
            rob_id_q[t] <= req_rob_id;
            pc_q[t]     <= req_pc;
            rd_q[t]     <= req_rd;
            dep1_q[t]   <= req_src1_rob_id;
            dep2_q[t]   <= req_src2_rob_id;
            src1_q[t]   <= req_hit1 ? wr_data : req_src1_data;
            src2_q[t]   <= req_hit2 ? wr_data : req_src2_data;
        end
        else
        begin
            if (cap1[t])
                src1_q[t] <= wr_data;
            if (cap2[t])
                src2_q[t] <= wr_data;
        end
    end
end

////////////////////////////////////////////////////////////////////////////
// Issue mux
////////////////////////////////////////////////////////////////////////////

always_comb
begin
    iss_thread = '0;
    for (int t = 0; t < `MUL_THREADS; t++)
    begin
        if (grant[t])
            iss_thread = mul_data_pkg::thread_id_t'(t);
    end
end

assign iss_rob_id = rob_id_q[iss_thread];
assign iss_pc     = pc_q[iss_thread];
assign iss_rd     = rd_q[iss_thread];
assign iss_src1   = src1_q[iss_thread];
assign iss_src2   = src2_q[iss_thread];

// Decode must hold off a thread whose slot is still occupied
assert property (@(posedge clock) disable iff (!rst_n)
    req_valid |-> !stall_decode[req_thread])
    else $error("request for thread %0d while its slot is occupied", req_thread);

endmodule

// ==== hdl/issue_arbiter.sv ====
`timescale 1ns/1ps
`include "mul_unit_cfg.svh"

module issue_arbiter
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  mul_ctrl_pkg::thread_mask_t slot_ready,
    output mul_ctrl_pkg::thread_mask_t grant,
    output logic                       grant_valid
);

// Thread with the highest priority this cycle
mul_data_pkg::thread_id_t ptr_q;
mul_data_pkg::thread_id_t ptr_next;

always_comb
begin
    int  idx;
    logic taken;
    grant    = '0;
    ptr_next = ptr_q;
    taken    = 1'b0;
    // Scan starting at the pointer and wrap around
    for (int i = 0; i < `MUL_THREADS; i++)
    begin
        idx = (int'(ptr_q) + i) % `MUL_THREADS;
        if (slot_ready[idx] && !taken)
        begin
            grant[idx] = 1'b1;
            ptr_next   = mul_data_pkg::thread_id_t'((idx + 1) % `MUL_THREADS);
            taken      = 1'b1;
        end
    end
end

assign grant_valid = |grant;

always_ff @(posedge clock)
begin
    if (!rst_n)
        ptr_q <= '0;
    else if (grant_valid)
        ptr_q <= ptr_next;
end

assert property (@(posedge clock) disable iff (!rst_n) $onehot0(grant))
    else $error("more than one thread granted");

assert property (@(posedge clock) disable iff (!rst_n) (grant & ~slot_ready) == '0)
    else $error("grant to a slot that is not ready");

endmodule

// ==== hdl/mul_stage.sv ====
`timescale 1ns/1ps
`include "mul_unit_cfg.svh"

module mul_stage
#(
    parameter int STAGE_INDEX = 0
)
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  mul_ctrl_pkg::thread_mask_t flush,

    input  logic                       in_valid,
    input  mul_data_pkg::thread_id_t   in_thread,
    input  mul_data_pkg::rob_id_t      in_rob_id,
    input  mul_data_pkg::pc_t          in_pc,
    input  mul_data_pkg::reg_addr_t    in_rd,
    input  mul_data_pkg::word_t        in_src1,
    input  mul_data_pkg::word_t        in_src2,
    input  mul_data_pkg::product_t     in_acc,

    output logic                       out_valid,
    output mul_data_pkg::thread_id_t   out_thread,
    output mul_data_pkg::rob_id_t      out_rob_id,
    output mul_data_pkg::pc_t          out_pc,
    output mul_data_pkg::reg_addr_t    out_rd,
    output mul_data_pkg::word_t        out_src1,
    output mul_data_pkg::word_t        out_src2,
    output mul_data_pkg::product_t     out_acc
);

// Bits of src2 handled per stage and where this stage's slice sits
localparam int SLICE_W = `MUL_DATA_WIDTH / `MUL_STAGES;
localparam int SHIFT   = STAGE_INDEX * SLICE_W;

mul_data_pkg::product_t partial;

// Unsigned partial product, aligned to the slice position
assign partial = (mul_data_pkg::product_t'(in_src1)
                  * mul_data_pkg::product_t'(in_src2[SHIFT +: SLICE_W])) << SHIFT;

always_ff @(posedge clock)
begin
    if (!rst_n)
        out_valid <= 1'b0;
    else
        out_valid <= in_valid && !flush[in_thread];
end

always_ff @(posedge clock)
begin
    out_thread <= in_thread;
    out_rob_id <= in_rob_id;
    out_pc     <= in_pc;
    out_rd     <= in_rd;
    out_src1   <= in_src1;
    out_src2   <= in_src2;
    out_acc    <= in_acc + partial;
end

endmodule

// ==== hdl/mul_writeback.sv ====
`timescale 1ns/1ps
`include "mul_unit_cfg.svh"

module mul_writeback
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  mul_ctrl_pkg::thread_mask_t flush,

    input  logic                       in_valid,
    input  mul_data_pkg::thread_id_t   in_thread,
    input  mul_data_pkg::rob_id_t      in_rob_id,
    input  mul_data_pkg::pc_t          in_pc,
    input  mul_data_pkg::reg_addr_t    in_rd,
    input  mul_data_pkg::product_t     in_acc,

    output logic                       res_valid,
    output mul_data_pkg::thread_id_t   res_thread,
    output mul_data_pkg::rob_id_t      res_rob_id,
    output mul_data_pkg::pc_t          res_pc,
    output mul_data_pkg::reg_addr_t    res_rd,
    output mul_data_pkg::word_t        res_data,
    output logic                       res_overflow
);

logic valid_q;

always_ff @(posedge clock)
begin
    if (!rst_n)
        valid_q <= 1'b0;
    else
        valid_q <= in_valid && !flush[in_thread];
end

always_ff @(posedge clock)
begin
    res_thread   <= in_thread;
    res_rob_id   <= in_rob_id;
    res_pc       <= in_pc;
    res_rd       <= in_rd;
    // Low word goes back to the register file
    res_data     <= in_acc[`MUL_DATA_WIDTH-1:0];
    // Any bit set in the high half means the result did not fit
    res_overflow <= |in_acc[2*`MUL_DATA_WIDTH-1:`MUL_DATA_WIDTH];
end

// A flush arriving while the result sits here still cancels it
assign res_valid = valid_q && !flush[res_thread];

endmodule

// ==== hdl/mul_unit_top.sv ====
`timescale 1ns/1ps
`include "mul_unit_cfg.svh"

module mul_unit_top
(
    input  logic                       clock,
    input  logic                       rst_n,

    input  logic                       req_valid,
    input  mul_data_pkg::thread_id_t   req_thread,
    input  mul_data_pkg::rob_id_t      req_rob_id,
    input  mul_data_pkg::pc_t          req_pc,
    input  mul_data_pkg::reg_addr_t    req_rd,
    input  mul_data_pkg::word_t        req_src1_data,
    input  logic                       req_src1_pending,
    input  mul_data_pkg::rob_id_t      req_src1_rob_id,
    input  mul_data_pkg::word_t        req_src2_data,
    input  logic                       req_src2_pending,
    input  mul_data_pkg::rob_id_t      req_src2_rob_id,
    output mul_ctrl_pkg::thread_mask_t stall_decode,

    input  logic                       wr_valid,
    input  mul_data_pkg::thread_id_t   wr_thread,
    input  mul_data_pkg::rob_id_t      wr_rob_id,
    input  mul_data_pkg::word_t        wr_data,

    input  mul_ctrl_pkg::thread_mask_t flush,

    output logic                       res_valid,
    output mul_data_pkg::thread_id_t   res_thread,
    output mul_data_pkg::rob_id_t      res_rob_id,
    output mul_data_pkg::pc_t          res_pc,
    output mul_data_pkg::reg_addr_t    res_rd,
    output mul_data_pkg::word_t        res_data,
    output logic                       res_overflow
);

mul_ctrl_pkg::thread_mask_t slot_ready;
mul_ctrl_pkg::thread_mask_t grant;
logic                       grant_valid;

// Index 0 is the issue point, index s+1 the output of stage s
logic                     st_valid [`MUL_STAGES+1];
mul_data_pkg::thread_id_t st_thread[`MUL_STAGES+1];
mul_data_pkg::rob_id_t    st_rob_id[`MUL_STAGES+1];
mul_data_pkg::pc_t        st_pc    [`MUL_STAGES+1];
mul_data_pkg::reg_addr_t  st_rd    [`MUL_STAGES+1];
mul_data_pkg::word_t      st_src1  [`MUL_STAGES+1];
mul_data_pkg::word_t      st_src2  [`MUL_STAGES+1];
mul_data_pkg::product_t   st_acc   [`MUL_STAGES+1];

operand_collector operand_collector_i
(
    .clock            ( clock            ),
    .rst_n            ( rst_n            ),
    .req_valid        ( req_valid        ),
    .req_thread       ( req_thread       ),
    .req_rob_id       ( req_rob_id       ),
    .req_pc           ( req_pc           ),
    .req_rd           ( req_rd           ),
    .req_src1_data    ( req_src1_data    ),
    .req_src1_pending ( req_src1_pending ),
    .req_src1_rob_id  ( req_src1_rob_id  ),
    .req_src2_data    ( req_src2_data    ),
    .req_src2_pending ( req_src2_pending ),
    .req_src2_rob_id  ( req_src2_rob_id  ),
    .wr_valid         ( wr_valid         ),
    .wr_thread        ( wr_thread        ),
    .wr_rob_id        ( wr_rob_id        ),
    .wr_data          ( wr_data          ),
    .flush            ( flush            ),
    .grant            ( grant            ),
    .stall_decode     ( stall_decode     ),
    .slot_ready       ( slot_ready       ),
    .iss_thread       ( st_thread[0]     ),
    .iss_rob_id       ( st_rob_id[0]     ),
    .iss_pc           ( st_pc[0]         ),
    .iss_rd           ( st_rd[0]         ),
    .iss_src1         ( st_src1[0]       ),
    .iss_src2         ( st_src2[0]       )
);

issue_arbiter issue_arbiter_i
(
    .clock       ( clock       ),
    .rst_n       ( rst_n       ),
    .slot_ready  ( slot_ready  ),
    .grant       ( grant       ),
    .grant_valid ( grant_valid )
);

// Issue slot starts with an empty accumulator
assign st_valid[0] = grant_valid;
assign st_acc[0]   = '0;

generate
    for (genvar s = 0; s < `MUL_STAGES; s++)
    begin : gen_stage
        mul_stage #(.STAGE_INDEX(s)) mul_stage_i
        (
            .clock      ( clock          ),
            .rst_n      ( rst_n          ),
            .flush      ( flush          ),
            .in_valid   ( st_valid[s]    ),
            .in_thread  ( st_thread[s]   ),
            .in_rob_id  ( st_rob_id[s]   ),
            .in_pc      ( st_pc[s]       ),
            .in_rd      ( st_rd[s]       ),
            .in_src1    ( st_src1[s]     ),
            .in_src2    ( st_src2[s]     ),
            .in_acc     ( st_acc[s]      ),
            .out_valid  ( st_valid[s+1]  ),
            .out_thread ( st_thread[s+1] ),
            .out_rob_id ( st_rob_id[s+1] ),
            .out_pc     ( st_pc[s+1]     ),
            .out_rd     ( st_rd[s+1]     ),
            .out_src1   ( st_src1[s+1]   ),
            .out_src2   ( st_src2[s+1]   ),
            .out_acc    ( st_acc[s+1]    )
        );
    end
endgenerate

mul_writeback mul_writeback_i
(
    .clock        ( clock                   ),
    .rst_n        ( rst_n                   ),
    .flush        ( flush                   ),
    .in_valid     ( st_valid[`MUL_STAGES]   ),
    .in_thread    ( st_thread[`MUL_STAGES]  ),
    .in_rob_id    ( st_rob_id[`MUL_STAGES]  ),
    .in_pc        ( st_pc[`MUL_STAGES]      ),
    .in_rd        ( st_rd[`MUL_STAGES]      ),
    .in_acc       ( st_acc[`MUL_STAGES]     ),
    .res_valid    ( res_valid               ),
    .res_thread   ( res_thread              ),
    .res_rob_id   ( res_rob_id              ),
    .res_pc       ( res_pc                  ),
    .res_rd       ( res_rd                  ),
    .res_data     ( res_data                ),
    .res_overflow ( res_overflow            )
);

endmodule

// ==== tb/tb_mul_unit.sv ====
`timescale 1ns/1ps
`include "mul_unit_cfg.svh"

module tb_mul_unit;

localparam int THREADS  = `MUL_THREADS;
localparam int W        = `MUL_DATA_WIDTH;
localparam int N_READY  = 40;
localparam int N_RANDOM = 80;
// Request count over all phases sizes the watchdog
localparam int NUM_TESTS = N_READY + 3 * THREADS + N_RANDOM + 14;
localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * (`MUL_STAGES + 20) * 4 * 4;
// Top rob id bit is never used by a pending source, so stray broadcasts miss
localparam mul_data_pkg::rob_id_t STRAY_BIT =
    mul_data_pkg::rob_id_t'(1) << (`MUL_ROB_ID_WIDTH - 1);

typedef struct packed {
    mul_data_pkg::rob_id_t   rob_id;
    mul_data_pkg::pc_t       pc;
    mul_data_pkg::reg_addr_t rd;
    mul_data_pkg::word_t     data;
    logic                    ovf;
} expect_t;

logic                       clock;
logic                       rst_n;
logic                       req_valid;
mul_data_pkg::thread_id_t   req_thread;
mul_data_pkg::rob_id_t      req_rob_id;
mul_data_pkg::pc_t          req_pc;
mul_data_pkg::reg_addr_t    req_rd;
mul_data_pkg::word_t        req_src1_data;
logic                       req_src1_pending;
mul_data_pkg::rob_id_t      req_src1_rob_id;
mul_data_pkg::word_t        req_src2_data;
logic                       req_src2_pending;
mul_data_pkg::rob_id_t      req_src2_rob_id;
mul_ctrl_pkg::thread_mask_t stall_decode;
logic                       wr_valid;
mul_data_pkg::thread_id_t   wr_thread;
mul_data_pkg::rob_id_t      wr_rob_id;
mul_data_pkg::word_t        wr_data;
mul_ctrl_pkg::thread_mask_t flush;
logic                       res_valid;
mul_data_pkg::thread_id_t   res_thread;
mul_data_pkg::rob_id_t      res_rob_id;
mul_data_pkg::pc_t          res_pc;
mul_data_pkg::reg_addr_t    res_rd;
mul_data_pkg::word_t        res_data;
logic                       res_overflow;

// Expected results per thread with the oldest first
expect_t exp_q [THREADS][$];

// Request currently held in each thread's slot
mul_data_pkg::rob_id_t   slot_rob [THREADS];
mul_data_pkg::pc_t       slot_pc  [THREADS];
mul_data_pkg::reg_addr_t slot_rd  [THREADS];
mul_data_pkg::word_t     op_a     [THREADS];
mul_data_pkg::word_t     op_b     [THREADS];
mul_data_pkg::rob_id_t   dep1     [THREADS];
mul_data_pkg::rob_id_t   dep2     [THREADS];
logic                    wait1    [THREADS];
logic                    wait2    [THREADS];

mul_unit_top mul_unit_top_i (.*);

always #2 clock = ~clock;

////////////////////////////////////////////////////////////////////////////
// Reference model and compare tasks
////////////////////////////////////////////////////////////////////////////

// Unsigned multiply giving the low word and a flag for a nonzero high word
function automatic mul_data_pkg::word_t ref_mul(input mul_data_pkg::word_t a,
                                                input mul_data_pkg::word_t b,
                                                output logic ovf);
    logic [2*W-1:0] full;
    full = {{W{1'b0}}, a} * {{W{1'b0}}, b};
    ovf  = |full[2*W-1:W];
    return full[W-1:0];
endfunction

task automatic report_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first error");
endtask

task automatic check_word(input mul_data_pkg::word_t got, input mul_data_pkg::word_t exp,
                          input string what);
    if (got !== exp)
    begin
        $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
        report_failure();
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
        $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
        report_failure();
    end
endtask

task automatic check_tag(input mul_data_pkg::rob_id_t got, input mul_data_pkg::rob_id_t exp,
                         input string what);
    if (got !== exp)
    begin
        $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
        report_failure();
    end
endtask

task automatic check_pc(input mul_data_pkg::pc_t got, input mul_data_pkg::pc_t exp,
                        input string what);
    if (got !== exp)
    begin
        $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
        report_failure();
    end
endtask

task automatic check_rd(input mul_data_pkg::reg_addr_t got, input mul_data_pkg::reg_addr_t exp,
                        input string what);
    if (got !== exp)
    begin
        $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
        report_failure();
    end
endtask

task automatic check_mask(input mul_ctrl_pkg::thread_mask_t got,
                          input mul_ctrl_pkg::thread_mask_t exp, input string what);
    if (got !== exp)
    begin
        $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
        report_failure();
    end
endtask

// Outputs are sampled mid cycle away from the driving edge
always @(negedge clock)
begin : compare_results
    expect_t e;
    if (rst_n && res_valid)
    begin
        if (exp_q[res_thread].size() == 0)
        begin
            $display("A result for thread %0d arrived with nothing expected", res_thread);
            report_failure();
        end
        else
        begin
            e = exp_q[res_thread].pop_front();
            check_tag(res_rob_id, e.rob_id, "result rob id");
            check_pc(res_pc, e.pc, "result pc");
            check_rd(res_rd, e.rd, "result rd");
            check_word(res_data, e.data, "result data");
            check_flag(res_overflow, e.ovf, "result overflow");
        end
    end
end

initial
begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    report_failure();
end

////////////////////////////////////////////////////////////////////////////
// Stimulus
////////////////////////////////////////////////////////////////////////////

// Short operands mixed with full ones give both overflow outcomes
function automatic mul_data_pkg::word_t rand_word();
    if ($urandom_range(0, 2) == 0)
        return mul_data_pkg::word_t'($urandom_range(0, 65535));
    return mul_data_pkg::word_t'($urandom);
endfunction

task automatic push_expect(input int t);
    expect_t e;
    logic    ovf;
    e.data   = ref_mul(op_a[t], op_b[t], ovf);
    e.ovf    = ovf;
    e.rob_id = slot_rob[t];
    e.pc     = slot_pc[t];
    e.rd     = slot_rd[t];
    exp_q[t].push_back(e);
endtask

task automatic broadcast(input int t, input mul_data_pkg::rob_id_t rob,
                         input mul_data_pkg::word_t data);
    @(posedge clock);
    wr_valid  <= 1'b1;
    wr_thread <= mul_data_pkg::thread_id_t'(t);
    wr_rob_id <= rob;
    wr_data   <= data;
    @(posedge clock);
    wr_valid  <= 1'b0;
endtask

// Pending sources carry junk data
// With same_wr the broadcast supplies src1 in the request cycle
task automatic send_req(input int t, input mul_data_pkg::word_t a, input mul_data_pkg::word_t b,
                        input logic pa, input logic pb, input logic same_wr);
    do
        @(negedge clock);
    while (stall_decode[t]);
    slot_rob[t] = mul_data_pkg::rob_id_t'($urandom);
    slot_pc[t]  = mul_data_pkg::pc_t'($urandom);
    slot_rd[t]  = mul_data_pkg::reg_addr_t'($urandom);
    op_a[t]     = a;
    op_b[t]     = b;
    dep1[t]     = mul_data_pkg::rob_id_t'(2 * $urandom_range(0, 15));
    dep2[t]     = dep1[t] | mul_data_pkg::rob_id_t'(1);
    wait1[t]    = pa && !same_wr;
    wait2[t]    = pb;
    @(posedge clock);
    req_valid        <= 1'b1;
    req_thread       <= mul_data_pkg::thread_id_t'(t);
    req_rob_id       <= slot_rob[t];
    req_pc           <= slot_pc[t];
    req_rd           <= slot_rd[t];
    req_src1_data    <= pa ? ~a : a;
    req_src1_pending <= pa;
    req_src1_rob_id  <= dep1[t];
    req_src2_data    <= pb ? ~b : b;
    req_src2_pending <= pb;
    req_src2_rob_id  <= dep2[t];
    if (pa && same_wr)
    begin
        wr_valid  <= 1'b1;
        wr_thread <= mul_data_pkg::thread_id_t'(t);
        wr_rob_id <= dep1[t];
        wr_data   <= a;
    end
    if (!wait1[t] && !wait2[t])
        push_expect(t);
    @(posedge clock);
    req_valid <= 1'b0;
    wr_valid  <= 1'b0;
endtask

// Supply whatever the parked request of thread t still waits for
task automatic resolve(input int t);
    logic any;
    any = wait1[t] || wait2[t];
    if (wait1[t])
        broadcast(t, dep1[t], op_a[t]);
    if (wait2[t])
        broadcast(t, dep2[t], op_b[t]);
    wait1[t] = 1'b0;
    wait2[t] = 1'b0;
    if (any)
        push_expect(t);
endtask

task automatic flush_thread(input int t);
    @(posedge clock);
    flush <= mul_ctrl_pkg::thread_mask_t'(1) << t;
    exp_q[t].delete();
    wait1[t] = 1'b0;
    wait2[t] = 1'b0;
    @(posedge clock);
    flush <= '0;
endtask

task automatic wait_drain();
    int left;
    do
    begin
        @(negedge clock);
        left = 0;
        for (int t = 0; t < THREADS; t++)
            left += exp_q[t].size();
    end
    while (left != 0);
    // Quiet window that catches any late extra result
    repeat (`MUL_STAGES + 2) @(negedge clock);
endtask

initial
begin : main_sequence
    int t;
    void'($urandom(78155));
    clock            = 1'b0;
    rst_n            <= 1'b0;
    req_valid        <= 1'b0;
    req_thread       <= '0;
    req_rob_id       <= '0;
    req_pc           <= '0;
    req_rd           <= '0;
    req_src1_data    <= '0;
    req_src1_pending <= 1'b0;
    req_src1_rob_id  <= '0;
    req_src2_data    <= '0;
    req_src2_pending <= 1'b0;
    req_src2_rob_id  <= '0;
    wr_valid         <= 1'b0;
    wr_thread        <= '0;
    wr_rob_id        <= '0;
    wr_data          <= '0;
    flush            <= '0;
    for (int i = 0; i < THREADS; i++)
    begin
        wait1[i] = 1'b0;
        wait2[i] = 1'b0;
    end
    repeat (8) @(posedge clock);
    rst_n <= 1'b1;

    // Idle after reset
    repeat (10)
    begin
        @(negedge clock);
        check_flag(res_valid, 1'b0, "res_valid after reset");
        check_mask(stall_decode, '0, "stall_decode after reset");
    end

    // Ready operands with corner values first
    send_req(0, '1, '1, 1'b0, 1'b0, 1'b0);
    send_req(1, '0, '1, 1'b0, 1'b0, 1'b0);
    send_req(2, mul_data_pkg::word_t'(1), '1, 1'b0, 1'b0, 1'b0);
    for (int n = 3; n < N_READY; n++)
        send_req($urandom_range(0, THREADS - 1), rand_word(), rand_word(), 1'b0, 1'b0, 1'b0);
    wait_drain();

    // Parked sources ignore broadcasts of another thread or tag
    for (int i = 0; i < THREADS; i++)
    begin
        send_req(i, rand_word(), rand_word(), 1'b1, (i % 2) == 0, 1'b0);
        broadcast((i + 1) % THREADS, dep1[i], rand_word());
        broadcast(i, dep1[i] | STRAY_BIT, rand_word());
        repeat (6) @(negedge clock);
        check_flag(stall_decode[i], 1'b1, "stall_decode while waiting");
        resolve(i);
    end
    wait_drain();

    // Broadcast in the request cycle
    for (int i = 0; i < THREADS; i++)
        send_req(i, rand_word(), rand_word(), 1'b1, 1'b0, 1'b1);
    for (int i = 0; i < THREADS; i++)
    begin
        send_req(i, rand_word(), rand_word(), 1'b1, 1'b1, 1'b1);
        resolve(i);
    end
    wait_drain();

    // Mixed traffic over all threads
    for (int n = 0; n < N_RANDOM; n++)
    begin
        t = $urandom_range(0, THREADS - 1);
        if ($urandom_range(0, 4) == 0)
            broadcast(t, mul_data_pkg::rob_id_t'($urandom_range(0, 15)) | STRAY_BIT,
                      rand_word());
        else if (wait1[t] || wait2[t])
            resolve(t);
        else
            send_req(t, rand_word(), rand_word(), $urandom_range(0, 2) == 0,
                     $urandom_range(0, 2) == 0, $urandom_range(0, 1) == 0);
        repeat ($urandom_range(0, 3)) @(posedge clock);
    end
    for (int i = 0; i < THREADS; i++)
        resolve(i);
    wait_drain();

    // Flush one thread with an item in flight and one parked
    for (int i = 0; i < THREADS; i += 2)
    begin
        send_req(i, rand_word(), rand_word(), 1'b0, 1'b0, 1'b0);
        send_req((i + 1) % THREADS, rand_word(), rand_word(), 1'b0, 1'b0, 1'b0);
        send_req(i, rand_word(), rand_word(), 1'b1, 1'b1, 1'b0);
        flush_thread(i);
        @(negedge clock);
        check_flag(stall_decode[i], 1'b0, "stall_decode after flush");
        // Flush while the item sits inside the multiplier stages
        send_req(i, rand_word(), rand_word(), 1'b0, 1'b0, 1'b0);
        flush_thread(i);
        send_req(i, rand_word(), rand_word(), 1'b0, 1'b0, 1'b0);
        send_req(i, rand_word(), rand_word(), 1'b1, 1'b0, 1'b0);
        resolve(i);
        wait_drain();
    end

    $display("ALL TESTS PASSED");
    $finish;
end

endmodule

// ==== files.f ====
+incdir+include
hdl/mul_data_pkg.sv
hdl/mul_ctrl_pkg.sv
hdl/operand_collector.sv
hdl/issue_arbiter.sv
hdl/mul_stage.sv
hdl/mul_writeback.sv
hdl/mul_unit_top.sv
tb/tb_mul_unit.sv

// ==== Makefile ====
# Verilator build and run for the multiply unit testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mul_unit
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the simulation output
run: compile
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
